// File: memPwr_settings.svh
// Word and bank counts must be powers of two with at least two banks, and the wake count nonzero
`ifndef MEMPWR_SETTINGS_SVH
`define MEMPWR_SETTINGS_SVH

// Logic banks, each a contiguous slice of the address space
`define MEM_NUM_BANKS 4

// Total words over all banks
`define MEM_NUM_WORDS 256

// Word width in bits
`define MEM_DATA_WIDTH 32

// Width of one byte lane
// Must divide MEM_DATA_WIDTH evenly
`define MEM_BYTE_WIDTH 8

// Settling cycles a bank waits after power-up
// The wake counter is sized from this value
`define MEM_WAKE_CYCLES 5

`endif

// File: memPwrPkg.sv
// Shared types for the power-managed memory; all widths follow the settings macros
`default_nettype none

`include "memPwr_settings.svh"

package memPwrPkg;

   localparam int unsigned AddrWidth     = $clog2(`MEM_NUM_WORDS);         // Full word address
   localparam int unsigned BankSelWidth  = $clog2(`MEM_NUM_BANKS);         // Top address bits
   localparam int unsigned BankAddrWidth = AddrWidth - BankSelWidth;       // Word within a bank
   localparam int unsigned BeWidth       = `MEM_DATA_WIDTH / `MEM_BYTE_WIDTH;
   localparam int unsigned TimerWidth    = $clog2(`MEM_WAKE_CYCLES + 1);   // Holds the full count

   typedef logic [AddrWidth-1:0]       addr_t;      // Word address at the port
   typedef logic [BankAddrWidth-1:0]   bankAddr_t;  // Address inside one bank
   typedef logic [BankSelWidth-1:0]    bankSel_t;   // Bank index
   typedef logic [`MEM_DATA_WIDTH-1:0] data_t;
   typedef logic [BeWidth-1:0]         be_t;        // Byte enables
   typedef logic [`MEM_NUM_BANKS-1:0]  bankVec_t;   // One bit per bank
   typedef logic [TimerWidth-1:0]      timer_t;     // Wake settling counter

   // Power mode of one bank
   typedef enum logic [1:0] {
      PWR_ON  = 2'd0,  // Full access
      PWR_RET = 2'd1,  // Deep sleep, contents kept
      PWR_OFF = 2'd2   // Power gated, contents lost
   } pwrMode_e;

   // Sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,   // Scan for a pending change
      SEQ_APPLY,  // Switch the chosen bank
      SEQ_WAKE,   // Wait for settling
      SEQ_DONE    // One cycle before the next scan
   } seqState_e;

endpackage

`default_nettype wire

// File: memBankSram.sv
// Behavioural bank only, not a macro model; array content is undefined until written after power-up
`default_nettype none

`include "memPwr_settings.svh"

module memBankSram (
   input  wire logic                 clk_i,        // Clock
   input  wire logic                 rst_ni,       // Async reset, active low
   input  wire logic                 req_i,        // Access strobe
   input  wire logic                 we_i,         // High for write, low for read
   input  wire memPwrPkg::bankAddr_t addr_i,       // Word inside this bank
   input  wire memPwrPkg::data_t     wdata_i,      // Write data
   input  wire memPwrPkg::be_t       be_i,         // Byte lanes to write
   input  wire logic                 deepSleep_i,  // Retention mode
   input  wire logic                 powerGate_i,  // Supply switched off
   output memPwrPkg::data_t          rdata_o       // Read data, one cycle after the request
);

   localparam int unsigned BankWords = `MEM_NUM_WORDS / `MEM_NUM_BANKS;
   localparam int unsigned NumBytes  = `MEM_DATA_WIDTH / `MEM_BYTE_WIDTH;
   localparam int unsigned ByteW     = `MEM_BYTE_WIDTH;

   memPwrPkg::data_t memArr [BankWords];  // Storage array

   logic awake;  // Bank is powered and out of retention
   logic wrEn;   // Write this cycle
   logic rdEn;   // Read this cycle

   // Both low-power modes block the port
   assign awake = !deepSleep_i && !powerGate_i;
   assign wrEn  = req_i && we_i && awake;
   assign rdEn  = req_i && !we_i && awake;

   // Array update
   // Power gate overrides any write and wipes every word
   always_ff @(posedge clk_i) begin
      if (powerGate_i) begin
         for (int w = 0; w < BankWords; w++) begin
            memArr[w] <= '0;  // Models loss of content
         end
      end else if (wrEn) begin
         for (int b = 0; b < NumBytes; b++) begin
            if (be_i[b]) begin
               memArr[addr_i][b*ByteW +: ByteW] <= wdata_i[b*ByteW +: ByteW];  // One lane
            end
         end
      end
   end

   // Registered read port
   // Holds the last value when no read happens
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_o <= '0;
      end else if (rdEn) begin
         rdata_o <= memArr[addr_i];  // Deep sleep keeps the old value here
      end
   end

endmodule

`default_nettype wire

// File: wakeTimer.sv
// Shared by all banks, so only one wake can be timed at once; done_o is high out of reset
`default_nettype none

`include "memPwr_settings.svh"

module wakeTimer (
   input  wire logic clk_i,   // Clock
   input  wire logic rst_ni,  // Async reset, active low
   input  wire logic load_i,  // Restart the settling count
   output logic      done_o   // High while the count is zero
);

   memPwrPkg::timer_t cntQ;  // Remaining settling cycles

   // Load wins over counting
   // Stops at zero until the next load
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cntQ <= '0;
      end else if (load_i) begin
         cntQ <= memPwrPkg::timer_t'(`MEM_WAKE_CYCLES);
      end else if (cntQ != '0) begin
         cntQ <= cntQ - 1'b1;
      end
   end

   assign done_o = (cntQ == '0);  // Level, not a pulse

endmodule

`default_nettype wire

// File: bankPwrFsm.sv
// One bank changes mode at a time, lowest index first; mode code 2'b11 is not a legal request
`default_nettype none

`include "memPwr_settings.svh"

module bankPwrFsm (
   input  wire logic [2*`MEM_NUM_BANKS-1:0] modeReq_i,    // Requested mode per bank, level
   input  wire logic                        clk_i,        // Clock
   input  wire logic                        rst_ni,       // Async reset, active low
   input  wire logic                        timerDone_i,  // Wake counter at zero
   output logic                             timerLoad_o,  // Start the settling count
   output logic [2*`MEM_NUM_BANKS-1:0]      curMode_o,    // Applied mode per bank
   output memPwrPkg::bankVec_t              deepSleep_o,  // Retention controls
   output memPwrPkg::bankVec_t              powerGate_o,  // Power gate controls
   output memPwrPkg::bankVec_t              bankReady_o   // On and settled
);

   localparam int unsigned NumBanks  = `MEM_NUM_BANKS;
   localparam int unsigned ModeWidth = $bits(memPwrPkg::pwrMode_e);

   memPwrPkg::seqState_e stateQ;
   memPwrPkg::seqState_e stateD;
   memPwrPkg::bankSel_t  activeQ;              // Bank being sequenced
   memPwrPkg::bankSel_t  pendIdx;              // Lowest bank with a pending change
   logic                 pendFound;
   memPwrPkg::pwrMode_e  reqMode  [NumBanks];  // Unpacked requests
   memPwrPkg::pwrMode_e  curModeQ [NumBanks];  // Applied modes
   memPwrPkg::bankVec_t  readyQ;

   for (genvar b = 0; b < NumBanks; b++) begin : gen_mode
      assign reqMode[b] = memPwrPkg::pwrMode_e'(modeReq_i[b*ModeWidth +: ModeWidth]);
      assign curMode_o[b*ModeWidth +: ModeWidth] = curModeQ[b];
      // Controls follow the applied mode directly
      assign deepSleep_o[b] = (curModeQ[b] == memPwrPkg::PWR_RET);
      assign powerGate_o[b] = (curModeQ[b] == memPwrPkg::PWR_OFF);
   end

   // Priority scan, the downward loop leaves the lowest match
   always_comb begin
      pendFound = 1'b0;
      pendIdx   = '0;
      for (int b = NumBanks - 1; b >= 0; b--) begin
         if (reqMode[b] != curModeQ[b]) begin
            pendFound = 1'b1;
            pendIdx   = memPwrPkg::bankSel_t'(b);
         end
      end
   end

   // Next state and timer load
   always_comb begin
      stateD      = stateQ;
      timerLoad_o = 1'b0;
      unique case (stateQ)
         memPwrPkg::SEQ_IDLE: begin
            if (pendFound) begin
               stateD = memPwrPkg::SEQ_APPLY;
            end
         end
         memPwrPkg::SEQ_APPLY: begin
            if (reqMode[activeQ] == memPwrPkg::PWR_ON) begin
               stateD      = memPwrPkg::SEQ_WAKE;
               timerLoad_o = 1'b1;  // Count starts with the mode change
            end else begin
               stateD = memPwrPkg::SEQ_DONE;  // Going down needs no settling
            end
         end
         memPwrPkg::SEQ_WAKE: begin
            if (timerDone_i) begin
               stateD = memPwrPkg::SEQ_DONE;
            end
         end
         default: stateD = memPwrPkg::SEQ_IDLE;  // SEQ_DONE
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         stateQ  <= memPwrPkg::SEQ_IDLE;
         activeQ <= '0;
         readyQ  <= '1;  // All banks start on and settled
         for (int b = 0; b < NumBanks; b++) begin
            curModeQ[b] <= memPwrPkg::PWR_ON;
         end
      end else begin
         stateQ <= stateD;
         if (stateQ == memPwrPkg::SEQ_IDLE && pendFound) begin
            activeQ <= pendIdx;  // Latch the bank to work on
         end
         if (stateQ == memPwrPkg::SEQ_APPLY) begin
            curModeQ[activeQ] <= reqMode[activeQ];  // Request as seen now
            readyQ[activeQ]   <= 1'b0;
         end
         if (stateQ == memPwrPkg::SEQ_WAKE && timerDone_i) begin
            readyQ[activeQ] <= 1'b1;  // Settled
         end
      end
   end

   assign bankReady_o = readyQ;

endmodule

`default_nettype wire

// File: memMultibankPwrgate.sv
// Single port with contiguous bank slices; accesses to unready banks are dropped and flagged, no stall
`default_nettype none

`include "memPwr_settings.svh"

module memMultibankPwrgate (
   input  wire logic                clk_i,        // Clock
   input  wire logic                rst_ni,       // Async reset, active low
   input  wire logic                req_i,        // Access strobe
   input  wire logic                we_i,         // Write enable
   input  wire memPwrPkg::addr_t    addr_i,       // Word address, bank in the top bits
   input  wire memPwrPkg::data_t    wdata_i,      // Write data
   input  wire memPwrPkg::be_t      be_i,         // Byte enables
   input  wire memPwrPkg::bankVec_t bankReady_i,  // Bank on and settled
   input  wire memPwrPkg::bankVec_t deepSleep_i,  // Retention per bank
   input  wire memPwrPkg::bankVec_t powerGate_i,  // Power gate per bank
   output memPwrPkg::data_t         rdata_o,      // Zero unless a good read was issued last cycle
   output logic                     accessErr_o   // Pulse for a dropped access
);

   localparam int unsigned NumBanks      = `MEM_NUM_BANKS;
   localparam int unsigned AddrWidth     = $bits(memPwrPkg::addr_t);
   localparam int unsigned SelWidth      = $bits(memPwrPkg::bankSel_t);
   localparam int unsigned BankAddrWidth = $bits(memPwrPkg::bankAddr_t);

   memPwrPkg::bankSel_t  bankSel;             // Decoded bank index
   logic                 selReady;            // Addressed bank can take the access
   memPwrPkg::bankVec_t  reqCut;              // Per-bank request after gating
   memPwrPkg::bankVec_t  weCut;
   memPwrPkg::bankAddr_t addrCut  [NumBanks];
   memPwrPkg::data_t     wdataCut [NumBanks];
   memPwrPkg::be_t       beCut    [NumBanks];
   memPwrPkg::data_t     rdataCut [NumBanks]; // Raw bank outputs

   memPwrPkg::bankSel_t  selQ;      // Bank of the access one cycle ago
   logic                 rdValidQ;  // That access was an accepted read
   logic                 errQ;      // That access hit an unready bank

   assign bankSel  = addr_i[AddrWidth-1 -: SelWidth];  // Upper bits pick the bank
   assign selReady = bankReady_i[bankSel];

   for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
      // Only the addressed and ready bank sees the request
      assign reqCut[b]   = req_i && selReady && (bankSel == memPwrPkg::bankSel_t'(b));
      assign weCut[b]    = reqCut[b] && we_i;
      // Idle banks get quiet inputs
      assign addrCut[b]  = reqCut[b] ? addr_i[BankAddrWidth-1:0] : '0;
      assign wdataCut[b] = reqCut[b] ? wdata_i : '0;
      assign beCut[b]    = reqCut[b] ? be_i : '0;

      memBankSram u_bank (
         .clk_i      (clk_i),
         .rst_ni     (rst_ni),
         .req_i      (reqCut[b]),
         .we_i       (weCut[b]),
         .addr_i     (addrCut[b]),
         .wdata_i    (wdataCut[b]),
         .be_i       (beCut[b]),
         .deepSleep_i(deepSleep_i[b]),
         .powerGate_i(powerGate_i[b]),
         .rdata_o    (rdataCut[b])
      );
   end

   // Read-select pipeline, matches the one-cycle bank latency
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         selQ     <= '0;
         rdValidQ <= 1'b0;
         errQ     <= 1'b0;
      end else begin
         selQ     <= bankSel;
         rdValidQ <= req_i && !we_i && selReady;
         errQ     <= req_i && !selReady;  // Reads and writes alike
      end
   end

   assign rdata_o     = rdValidQ ? rdataCut[selQ] : '0;  // Steer with the stored select
   assign accessErr_o = errQ;

endmodule

`default_nettype wire

// File: memPwrTop.sv
// Single-port memory with per-bank power modes; modeReq_i is a level and must hold until applied
`default_nettype none

`include "memPwr_settings.svh"

module memPwrTop (
   input  wire logic                        clk_i,        // Clock
   input  wire logic                        rst_ni,       // Async reset, active low
   input  wire logic                        req_i,        // Access strobe
   input  wire logic                        we_i,         // Write enable
   input  wire memPwrPkg::addr_t            addr_i,       // Word address
   input  wire memPwrPkg::data_t            wdata_i,      // Write data
   input  wire memPwrPkg::be_t              be_i,         // Byte enables
   input  wire logic [2*`MEM_NUM_BANKS-1:0] modeReq_i,    // Packed pwrMode_e per bank
   output memPwrPkg::data_t                 rdata_o,      // Read data, one cycle latency
   output logic                             accessErr_o,  // Dropped access flag
   output memPwrPkg::bankVec_t              bankReady_o,  // On and settled per bank
   output logic [2*`MEM_NUM_BANKS-1:0]      curMode_o     // Applied mode per bank
);

   memPwrPkg::bankVec_t deepSleep;  // Retention controls to the banks
   memPwrPkg::bankVec_t powerGate;  // Gate controls to the banks
   memPwrPkg::bankVec_t bankReady;  // Access gating and status
   logic                timerLoad;  // Sequencer starts settling
   logic                timerDone;  // Settling over

   // Power sequencer
   bankPwrFsm u_seq (
      .modeReq_i  (modeReq_i),
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .timerDone_i(timerDone),
      .timerLoad_o(timerLoad),
      .curMode_o  (curMode_o),
      .deepSleep_o(deepSleep),
      .powerGate_o(powerGate),
      .bankReady_o(bankReady)
   );

   // Shared wake counter
   wakeTimer u_timer (
      .clk_i (clk_i),
      .rst_ni(rst_ni),
      .load_i(timerLoad),
      .done_o(timerDone)
   );

   // Banked array with access gating
   memMultibankPwrgate u_mem (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (req_i),
      .we_i       (we_i),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .be_i       (be_i),
      .bankReady_i(bankReady),
      .deepSleep_i(deepSleep),
      .powerGate_i(powerGate),
      .rdata_o    (rdata_o),
      .accessErr_o(accessErr_o)
   );

   assign bankReady_o = bankReady;  // Same status the memory uses

endmodule

`default_nettype wire

// File: memPwrTb_assert.sv
// Bound into memPwrTop; reaches the sequencer's deepSleep and powerGate nets through the bind ports
`default_nettype none

`include "memPwr_settings.svh"

module memPwrTbAssert (
   input wire logic                        clk_i,
   input wire logic                        rst_ni,
   input wire logic                        accessErr_i,
   input wire memPwrPkg::data_t            rdata_i,
   input wire memPwrPkg::bankVec_t         bankReady_i,
   input wire logic [2*`MEM_NUM_BANKS-1:0] curMode_i,    // Packed pwrMode_e per bank
   input wire memPwrPkg::bankVec_t         deepSleep_i,
   input wire memPwrPkg::bankVec_t         powerGate_i
);
   timeunit 1ns;
   timeprecision 1ps;

   memPwrPkg::bankVec_t onVec;    // Applied mode is PWR_ON
   int unsigned errFail   = 0;
   int unsigned modeFail  = 0;
   int unsigned ctrlFail  = 0;
   int unsigned failCnt;          // Read by the testbench at the end

   always_comb begin
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         onVec[b] = (curMode_i[2*b +: 2] == memPwrPkg::PWR_ON);
      end
   end

   assign failCnt = errFail + modeFail + ctrlFail;

   // A dropped access never carries data
   errNoData: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(accessErr_i && (rdata_i != '0)))
      else begin
         errFail++;
         $error("accessErr_o high together with nonzero rdata_o");
      end

   // Rising ready bits only on banks that are on
   readyNeedsOn: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((bankReady_i & ~$past(bankReady_i)) & ~onVec) == '0)
      else begin
         modeFail++;
         $error("bankReady_o rose for a bank that is not in PWR_ON");
      end

   // Low-power controls released before ready
   readyNeedsAwake: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((bankReady_i & ~$past(bankReady_i)) & (deepSleep_i | powerGate_i)) == '0)
      else begin
         ctrlFail++;
         $error("bankReady_o rose while deepSleep or powerGate was high");
      end

endmodule

`default_nettype wire

// File: memPwrTb.sv
// Word-level model follows bankReady_o; all words are written once before any read
`default_nettype none

`include "memPwr_settings.svh"

module memPwrTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned NumBanks  = `MEM_NUM_BANKS;
   localparam int unsigned NumWords  = `MEM_NUM_WORDS;
   localparam int unsigned BankWords = NumWords / NumBanks;
   localparam int unsigned ByteW     = `MEM_BYTE_WIDTH;
   localparam int unsigned RandOps   = 300;
   localparam int unsigned PlannedCycles = 16 + (NumWords + RandOps) + 140 + (NumWords + 40)
                                           + 40 + (NumWords + 80);  // Reset, then tests 1 to 5
   localparam int unsigned CycleLimit = 4 * PlannedCycles;

   logic                  clk_i = 1'b0;
   logic                  rst_ni;
   logic                  req_i;
   logic                  we_i;
   memPwrPkg::addr_t      addr_i;
   memPwrPkg::data_t      wdata_i;
   memPwrPkg::be_t        be_i;
   logic [2*NumBanks-1:0] modeReq_i;
   memPwrPkg::data_t      rdata_o;
   logic                  accessErr_o;
   memPwrPkg::bankVec_t   bankReady_o;
   logic [2*NumBanks-1:0] curMode_o;

   memPwrPkg::data_t      model [NumWords];  // Reference contents
   logic [2*NumBanks-1:0] lastMode;          // curMode_o at the previous sample
   int unsigned           chgBank [$];       // Banks in order of mode change
   int unsigned           cycleCnt = 0;
   int unsigned           errCnt   = 0;
   int unsigned           checkCnt = 0;
   int unsigned           errMark;
   int unsigned           wakeCnt;

   always #5 clk_i = ~clk_i;  // 10 ns period

   memPwrTop u_dut (
      .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .we_i(we_i), .addr_i(addr_i),
      .wdata_i(wdata_i), .be_i(be_i), .modeReq_i(modeReq_i), .rdata_o(rdata_o),
      .accessErr_o(accessErr_o), .bankReady_o(bankReady_o), .curMode_o(curMode_o)
   );

   bind memPwrTop memPwrTbAssert u_assert (
      .clk_i(clk_i), .rst_ni(rst_ni), .accessErr_i(accessErr_o), .rdata_i(rdata_o),
      .bankReady_i(bankReady_o), .curMode_i(curMode_o), .deepSleep_i(deepSleep),
      .powerGate_i(powerGate)
   );

   // Hang guard
   always @(posedge clk_i) begin
      cycleCnt++;
      if (cycleCnt >= CycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
         $display("test failed");
         $finish;
      end
   end

   function automatic memPwrPkg::data_t mergeBytes(input memPwrPkg::data_t old,
         input memPwrPkg::data_t wd, input memPwrPkg::be_t be);
      memPwrPkg::data_t res;
      res = old;
      for (int i = 0; i < $bits(be); i++) begin
         if (be[i]) begin
            res[ByteW*i +: ByteW] = wd[ByteW*i +: ByteW];  // Enabled lane only
         end
      end
      return res;
   endfunction

   function automatic memPwrPkg::bankVec_t onMask();  // Banks requested on
      memPwrPkg::bankVec_t m;
      for (int b = 0; b < NumBanks; b++) begin
         m[b] = (modeReq_i[2*b +: 2] == memPwrPkg::PWR_ON);
      end
      return m;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
      checkCnt++;
      assert (got === exp) else begin
         errCnt++;
         $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // Records mode changes and clears the model words of a bank switched off
   task automatic sampleModes();
      int nChg;
      nChg = 0;
      for (int b = 0; b < NumBanks; b++) begin
         if (curMode_o[2*b +: 2] != lastMode[2*b +: 2]) begin
            nChg++;
            chgBank.push_back(b);
            // Ready drops at the same edge as the mode
            checkVal($sformatf("bankReady_o[%0d]", b), 32'd0, 32'(bankReady_o[b]));
            if (curMode_o[2*b +: 2] == memPwrPkg::PWR_OFF) begin
               for (int w = 0; w < BankWords; w++) begin
                  model[b*BankWords + w] = '0;
               end
            end
         end
      end
      lastMode = curMode_o;
      checkCnt++;
      assert (nChg <= 1) else begin
         errCnt++;
         $display("At %0t more than one bank changed mode in one cycle", $time);
      end
   endtask

   // One port cycle; response checked after the edge
   task automatic access(input logic req, input logic we, input memPwrPkg::addr_t addr,
         input memPwrPkg::data_t wd, input memPwrPkg::be_t be);
      memPwrPkg::data_t expData;
      logic             expErr;
      int unsigned      bank;
      bank    = addr / BankWords;
      expData = '0;
      expErr  = 1'b0;
      req_i   = req;
      we_i    = we;
      addr_i  = addr;
      wdata_i = wd;
      be_i    = be;
      if (req && !bankReady_o[bank]) begin
         expErr = 1'b1;  // Dropped
      end else if (req && we) begin
         model[addr] = mergeBytes(model[addr], wd, be);
      end else if (req) begin
         expData = model[addr];
      end
      @(posedge clk_i);
      #1;
      sampleModes();
      checkVal("rdata_o", expData, rdata_o);
      checkVal("accessErr_o", 32'(expErr), 32'(accessErr_o));
      req_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic randAccess(input int unsigned bank);
      access(1'b1, 1'($urandom), memPwrPkg::addr_t'(bank*BankWords + $urandom % BankWords),
             $urandom, memPwrPkg::be_t'($urandom));
   endtask

   task automatic idle();
      access(1'b0, 1'b0, '0, '0, '0);
   endtask

   task automatic readAll();
      for (int a = 0; a < NumWords; a++) begin
         access(1'b1, 1'b0, memPwrPkg::addr_t'(a), '0, '0);
      end
   endtask

   // Waits until every request is applied and settled, with random traffic if busy
   task automatic settle(input logic busy);
      while (curMode_o != modeReq_i || bankReady_o != onMask()) begin
         if (busy) begin
            randAccess($urandom % NumBanks);
         end else begin
            idle();
         end
      end
      repeat (2) idle();  // Sequencer back in idle
   endtask

   task automatic checkOrder(input int unsigned nExp);
      checkCnt++;
      assert (chgBank.size() == nExp) else begin
         errCnt++;
         $display("Expected %0d mode changes but saw %0d", nExp, chgBank.size());
      end
      for (int i = 1; i < chgBank.size(); i++) begin
         checkCnt++;
         assert (chgBank[i] > chgBank[i-1]) else begin
            errCnt++;
            $display("Bank %0d changed mode after bank %0d", chgBank[i], chgBank[i-1]);
         end
      end
   endtask

   task automatic report(input int n, input string name);
      $display("[%0d] %s: %0d errors", n, name, errCnt - errMark);
      errMark = errCnt;
   endtask

   initial begin
      rst_ni    = 1'b0;
      req_i     = 1'b0;
      we_i      = 1'b0;
      addr_i    = '0;
      wdata_i   = '0;
      be_i      = '0;
      modeReq_i = '0;  // All PWR_ON
      errMark   = 0;
      void'($urandom(10190));
      repeat (16) @(posedge clk_i);
      #1;
      rst_ni   = 1'b1;
      lastMode = curMode_o;

      // Reset state, every bank on and ready with a quiet port
      checkVal("curMode_o", 32'({NumBanks{2'(memPwrPkg::PWR_ON)}}), 32'(curMode_o));
      checkVal("bankReady_o", 32'({NumBanks{1'b1}}), 32'(bankReady_o));
      checkVal("rdata_o", 32'd0, rdata_o);
      checkVal("accessErr_o", 32'd0, 32'(accessErr_o));

      // Test 1 fills every word, then runs random traffic
      for (int a = 0; a < NumWords; a++) begin
         access(1'b1, 1'b1, memPwrPkg::addr_t'(a), $urandom, '1);
      end
      for (int i = 0; i < RandOps; i++) begin
         randAccess($urandom % NumBanks);
      end
      report(1, "random access, all banks on");

      // Test 2 checks that retention keeps contents
      modeReq_i[2*2 +: 2] = memPwrPkg::PWR_RET;
      settle(1'b0);
      for (int i = 0; i < 60; i++) begin
         randAccess((i < 40) ? 2 : $urandom % NumBanks);  // Mostly the sleeping bank
      end
      modeReq_i[2*2 +: 2] = memPwrPkg::PWR_ON;
      settle(1'b0);
      for (int w = 0; w < BankWords; w++) begin
         access(1'b1, 1'b0, memPwrPkg::addr_t'(2*BankWords + w), '0, '0);
      end
      report(2, "retention");

      // Test 3 gates one bank, which alone loses its contents
      modeReq_i[2*1 +: 2] = memPwrPkg::PWR_OFF;
      settle(1'b0);
      modeReq_i[2*1 +: 2] = memPwrPkg::PWR_ON;
      settle(1'b0);
      readAll();
      report(3, "power gate");

      // Test 4 times the wake settling
      modeReq_i[2*3 +: 2] = memPwrPkg::PWR_RET;
      settle(1'b0);
      modeReq_i[2*3 +: 2] = memPwrPkg::PWR_ON;
      while (curMode_o[2*3 +: 2] != memPwrPkg::PWR_ON) begin
         idle();
      end
      wakeCnt = 0;
      while (!bankReady_o[3]) begin
         idle();
         wakeCnt++;
      end
      checkVal("wake cycles", `MEM_WAKE_CYCLES + 1, wakeCnt);
      settle(1'b0);
      report(4, "wake timing");

      // Test 5 changes several banks at once, lowest index first
      chgBank.delete();
      modeReq_i[2*0 +: 2] = memPwrPkg::PWR_OFF;
      modeReq_i[2*1 +: 2] = memPwrPkg::PWR_RET;
      modeReq_i[2*3 +: 2] = memPwrPkg::PWR_RET;
      settle(1'b1);
      checkOrder(3);
      chgBank.delete();
      modeReq_i = '0;
      settle(1'b1);
      checkOrder(3);
      readAll();
      report(5, "sequencing");

      $display("Checks %0d, errors %0d, assertion failures %0d", checkCnt, errCnt,
               u_dut.u_assert.failCnt);
      if (errCnt == 0 && u_dut.u_assert.failCnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
memPwrPkg.sv
memBankSram.sv
wakeTimer.sv
bankPwrFsm.sv
memMultibankPwrgate.sv
memPwrTop.sv
memPwrTb_assert.sv
memPwrTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module memPwrTb -o memPwrSim &&
./obj_dir/memPwrSim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "test passed" &&
echo "Simulation OK" || { echo "Simulation FAILED"; exit 1; }
